//--- source/mtx_pkg.sv
package mtx_pkg;

  localparam int PHASE_W    = 24;
  localparam int SAMPLE_W   = 16;
  localparam int SYMB_W     = 16;  // symbol index width in status
  localparam int NSIG       = 64;  // samples per symbol
  localparam int NSYMB      = 8;   // symbols per frame
  localparam int SYNC_BITS  = 3;
  localparam int LUT_ADDR_W = 8;   // quarter table, 256 entries

  localparam logic [PHASE_W-1:0] START_PH     = 24'h000000;
  localparam logic [PHASE_W-1:0] START_PH_INC = 24'd4096;
  localparam logic [PHASE_W-1:0] DPH_INC      = 24'd16384;
  localparam logic [PHASE_W-1:0] FREQ_SHIFT   = 24'd8192;
  localparam logic [PHASE_W-1:0] NPH_SHIFT    = 24'h020000;

  // two full tones overshoot 16-bit full scale
  localparam int TONE_AMPL = 'h5000;

  typedef struct packed {
    logic [PHASE_W-1:0] phase;
    logic               last;
  } phase_beat_t;

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] sine;
    logic signed [SAMPLE_W-1:0] cosine;
  } tone_t;

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } iq_t;

  typedef struct packed {
    logic [PHASE_W-1:0] ph;        // tone a phase
    logic [PHASE_W-1:0] ph_start;  // start phase of current symbol
    logic [PHASE_W-1:0] sig_n;     // sample index
    logic [SYMB_W-1:0]  symb_n;    // symbol index, 1 based
  } gen_status_t;

  // quadrant from the top two phase bits
  typedef enum logic [1:0] {
    q0 = 2'd0,
    q1 = 2'd1,
    q2 = 2'd2,
    q3 = 2'd3
  } quad_e;

  // table entry k holds the sine at the middle of step k,
  // so entry 255-k is the cosine of the same angle
  function automatic logic signed [SAMPLE_W-1:0] sine_entry(input int idx);
    real angle;
    int  value;
    angle = (real'(idx) + 0.5) * 3.141592653589793 / 512.0;
    value = int'(real'(TONE_AMPL) * $sin(angle));  // cast rounds
    return SAMPLE_W'(value);
  endfunction

endpackage

//--- source/chirp_phase_gen.sv
module chirp_phase_gen (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 restart,
  input  logic                 phase_ready,
  output logic                 phase_valid,
  output mtx_pkg::phase_beat_t phase_a,
  output mtx_pkg::phase_beat_t phase_b,
  output logic                 sync_ready,
  output mtx_pkg::gen_status_t status
);

  logic [mtx_pkg::PHASE_W-1:0]   samp_cnt;   // sample index in symbol
  logic [mtx_pkg::SYMB_W-1:0]    symb_cnt;   // 1 .. NSYMB
  logic [mtx_pkg::SYNC_BITS-1:0] frame_cnt;
  logic [mtx_pkg::PHASE_W-1:0]   acc_a;
  logic [mtx_pkg::PHASE_W-1:0]   acc_b;
  logic [mtx_pkg::PHASE_W-1:0]   inc_a;
  logic [mtx_pkg::PHASE_W-1:0]   inc_b;
  logic [mtx_pkg::PHASE_W-1:0]   start_ph;   // tone a start of this symbol
  logic                          accept;
  logic                          symb_end;
  logic                          frame_end;

  assign accept    = phase_valid && phase_ready;
  assign symb_end  = samp_cnt == mtx_pkg::PHASE_W'(mtx_pkg::NSIG - 1);
  assign frame_end = symb_end && (symb_cnt == mtx_pkg::SYMB_W'(mtx_pkg::NSYMB));

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      phase_valid <= !rst;  // a restart keeps one beat pending
      samp_cnt    <= '0;
      symb_cnt    <= mtx_pkg::SYMB_W'(1);
      frame_cnt   <= '0;
      acc_a       <= mtx_pkg::START_PH;
      acc_b       <= mtx_pkg::START_PH;
      inc_a       <= mtx_pkg::START_PH_INC;
      inc_b       <= mtx_pkg::START_PH_INC + mtx_pkg::FREQ_SHIFT;
      start_ph    <= mtx_pkg::START_PH;
    end else begin
      phase_valid <= 1'b1;
      if (accept) begin
        if (frame_end) begin
          // back to symbol 1 of the next frame
          samp_cnt  <= '0;
          symb_cnt  <= mtx_pkg::SYMB_W'(1);
          frame_cnt <= frame_cnt + 1'b1;
          acc_a     <= mtx_pkg::START_PH;
          acc_b     <= mtx_pkg::START_PH;
          inc_a     <= mtx_pkg::START_PH_INC;
          inc_b     <= mtx_pkg::START_PH_INC + mtx_pkg::FREQ_SHIFT;
          start_ph  <= mtx_pkg::START_PH;
        end else if (symb_end) begin
          samp_cnt <= '0;
          symb_cnt <= symb_cnt + 1'b1;
          acc_a    <= start_ph - mtx_pkg::NPH_SHIFT;  // start slides back
          acc_b    <= mtx_pkg::START_PH;              // tone b always restarts
          inc_a    <= inc_a + mtx_pkg::DPH_INC;
          inc_b    <= inc_b + mtx_pkg::DPH_INC;       // keeps the fixed offset
          start_ph <= start_ph - mtx_pkg::NPH_SHIFT;
        end else begin
          samp_cnt <= samp_cnt + 1'b1;
          acc_a    <= acc_a + inc_a;
          acc_b    <= acc_b + inc_b;
        end
      end
    end
  end

  assign phase_a.phase = acc_a;
  assign phase_a.last  = symb_end;
  assign phase_b.phase = acc_b;
  assign phase_b.last  = symb_end;

  assign sync_ready = frame_cnt == '0;  // one frame in eight

  assign status.ph       = acc_a;
  assign status.ph_start = start_ph;
  assign status.sig_n    = samp_cnt;
  assign status.symb_n   = symb_cnt;

  // pending beat must not change until taken
  property p_phase_hold;
    @(posedge clk) disable iff (rst)
      phase_valid && !phase_ready && !restart |=> $stable(phase_a);
  endproperty
  a_phase_hold : assert property (p_phase_hold)
    else $error("phase_a changed while stalled");

  property p_samp_range;
    @(posedge clk) disable iff (rst)
      samp_cnt < mtx_pkg::PHASE_W'(mtx_pkg::NSIG);
  endproperty
  a_samp_range : assert property (p_samp_range)
    else $error("sample index out of range");

endmodule

//--- source/sin_cos_lut.sv
module sin_cos_lut (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 restart,
  input  mtx_pkg::phase_beat_t phase,
  input  logic                 phase_valid,
  output logic                 phase_ready,
  output mtx_pkg::tone_t       tone,
  output logic                 tone_valid,
  output logic                 tone_last,
  input  logic                 tone_ready
);

  localparam int TBL_N = 1 << mtx_pkg::LUT_ADDR_W;

  logic signed [mtx_pkg::SAMPLE_W-1:0] quarter [TBL_N];

  logic [mtx_pkg::LUT_ADDR_W-1:0]      idx;
  mtx_pkg::quad_e                      quad;
  logic                                odd_quad;

  logic                                s1_valid;
  logic                                s1_last;
  mtx_pkg::quad_e                      s1_quad;
  logic [mtx_pkg::LUT_ADDR_W-1:0]      s1_sin_addr;
  logic [mtx_pkg::LUT_ADDR_W-1:0]      s1_cos_addr;

  logic signed [mtx_pkg::SAMPLE_W-1:0] sin_mag;
  logic signed [mtx_pkg::SAMPLE_W-1:0] cos_mag;
  logic                                s1_en;
  logic                                s2_en;

  // constant quarter wave
  for (genvar k = 0; k < TBL_N; k++) begin : g_table
    assign quarter[k] = mtx_pkg::sine_entry(k);
  end

  assign s2_en       = !tone_valid || tone_ready;
  assign s1_en       = !s1_valid || s2_en;
  assign phase_ready = s1_en;

  // top ten phase bits
  assign quad     = mtx_pkg::quad_e'(phase.phase[mtx_pkg::PHASE_W-1 -: 2]);
  assign idx      = phase.phase[mtx_pkg::PHASE_W-3 -: mtx_pkg::LUT_ADDR_W];
  assign odd_quad = phase.phase[mtx_pkg::PHASE_W-2];

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      s1_valid   <= 1'b0;
      tone_valid <= 1'b0;
      tone_last  <= 1'b0;
    end else begin
      if (s1_en) begin
        s1_valid <= phase_valid;
      end
      if (s2_en) begin
        tone_valid <= s1_valid;
        tone_last  <= s1_valid && s1_last;
      end
    end
  end

  // stage 1: quadrant and table addresses
  always_ff @(posedge clk) begin
    if (s1_en) begin
      s1_quad     <= quad;
      s1_last     <= phase.last;
      s1_sin_addr <= odd_quad ? ~idx : idx;  // mirrored in q1 and q3
      s1_cos_addr <= odd_quad ? idx : ~idx;
    end
  end

  assign sin_mag = quarter[s1_sin_addr];
  assign cos_mag = quarter[s1_cos_addr];

  // stage 2: table read and quadrant signs
  always_ff @(posedge clk) begin
    if (s2_en) begin
      case (s1_quad)
        mtx_pkg::q0: begin
          tone.sine   <= sin_mag;
          tone.cosine <= cos_mag;
        end
        mtx_pkg::q1: begin
          tone.sine   <= sin_mag;
          tone.cosine <= -cos_mag;
        end
        mtx_pkg::q2: begin
          tone.sine   <= -sin_mag;
          tone.cosine <= -cos_mag;
        end
        default: begin  // q3
          tone.sine   <= -sin_mag;
          tone.cosine <= cos_mag;
        end
      endcase
    end
  end

  property p_no_valid_after_rst;
    @(posedge clk) $past(rst) |-> !tone_valid;
  endproperty
  a_no_valid_after_rst : assert property (p_no_valid_after_rst)
    else $error("tone_valid high right after reset");

endmodule

//--- source/tone_combiner.sv
module tone_combiner (
  input  logic           clk,
  input  logic           rst,
  input  logic           restart,
  input  mtx_pkg::tone_t tone_a,
  input  mtx_pkg::tone_t tone_b,
  input  logic           tone_valid,
  input  logic           tone_last,
  output logic           tone_ready,
  output mtx_pkg::iq_t   iq,
  output logic           out_valid,
  output logic           out_last,
  input  logic           out_ready
);

  logic signed [mtx_pkg::SAMPLE_W:0] sum_i;  // one bit of headroom
  logic signed [mtx_pkg::SAMPLE_W:0] sum_q;

  function automatic logic signed [mtx_pkg::SAMPLE_W-1:0] sat(
    input logic signed [mtx_pkg::SAMPLE_W:0] s
  );
    logic overflow;
    overflow = s[mtx_pkg::SAMPLE_W] != s[mtx_pkg::SAMPLE_W-1];
    if (!overflow) begin
      return s[mtx_pkg::SAMPLE_W-1:0];
    end
    // clip to the rail on the side of the true sign
    return s[mtx_pkg::SAMPLE_W] ? {1'b1, {(mtx_pkg::SAMPLE_W-1){1'b0}}}
                                : {1'b0, {(mtx_pkg::SAMPLE_W-1){1'b1}}};
  endfunction

  assign sum_i = {tone_a.cosine[mtx_pkg::SAMPLE_W-1], tone_a.cosine}
               + {tone_b.cosine[mtx_pkg::SAMPLE_W-1], tone_b.cosine};
  assign sum_q = {tone_a.sine[mtx_pkg::SAMPLE_W-1], tone_a.sine}
               + {tone_b.sine[mtx_pkg::SAMPLE_W-1], tone_b.sine};

  assign tone_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst || restart) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (tone_ready) begin
      out_valid <= tone_valid;
      out_last  <= tone_valid && tone_last;
    end
  end

  always_ff @(posedge clk) begin
    if (tone_ready && tone_valid) begin
      iq.i <= sat(sum_i);
      iq.q <= sat(sum_q);
    end
  end

  property p_iq_hold;
    @(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> $stable(iq);
  endproperty
  a_iq_hold : assert property (p_iq_hold)
    else $error("iq changed while stalled");

endmodule

//--- source/mtx_sig_top.sv
module mtx_sig_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 restart,
  input  logic                 out_ready,
  output mtx_pkg::iq_t         iq,
  output logic                 out_valid,
  output logic                 out_last,
  output logic                 sync_ready,
  output mtx_pkg::gen_status_t status
);

  mtx_pkg::phase_beat_t phase_a;
  mtx_pkg::phase_beat_t phase_b;
  logic                 phase_valid;
  logic                 phase_ready;

  mtx_pkg::tone_t       tone_a;
  mtx_pkg::tone_t       tone_b;
  logic                 tone_valid;
  logic                 tone_last;
  logic                 tone_ready;

  chirp_phase_gen u_phase_gen (
    .clk         (clk),
    .rst         (rst),
    .restart     (restart),
    .phase_ready (phase_ready),
    .phase_valid (phase_valid),
    .phase_a     (phase_a),
    .phase_b     (phase_b),
    .sync_ready  (sync_ready),
    .status      (status)
  );

  // lane a carries the handshake for both lanes
  sin_cos_lut u_lut_a (
    .clk         (clk),
    .rst         (rst),
    .restart     (restart),
    .phase       (phase_a),
    .phase_valid (phase_valid),
    .phase_ready (phase_ready),
    .tone        (tone_a),
    .tone_valid  (tone_valid),
    .tone_last   (tone_last),
    .tone_ready  (tone_ready)
  );

  sin_cos_lut u_lut_b (
    .clk         (clk),
    .rst         (rst),
    .restart     (restart),
    .phase       (phase_b),
    .phase_valid (phase_valid),
    .phase_ready (),            // same enable as lane a
    .tone        (tone_b),
    .tone_valid  (),
    .tone_last   (),
    .tone_ready  (tone_ready)
  );

  tone_combiner u_combiner (
    .clk        (clk),
    .rst        (rst),
    .restart    (restart),
    .tone_a     (tone_a),
    .tone_b     (tone_b),
    .tone_valid (tone_valid),
    .tone_last  (tone_last),
    .tone_ready (tone_ready),
    .iq         (iq),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_ready  (out_ready)
  );

endmodule

//--- test/tb_mtx_sig.sv
module tb_mtx_sig;

  localparam int  CLK_PERIOD = 40;
  localparam int  RST_CYCLES = 8;
  localparam int  FRAME_LEN  = mtx_pkg::NSIG * mtx_pkg::NSYMB;  // samples per frame
  localparam int  IDX_W      = $clog2(FRAME_LEN);
  localparam int  WATCHDOG_T = CLK_PERIOD * (3 * FRAME_LEN * 3 + 2000);
  localparam int  TOL        = 2;  // lsb
  localparam int  FS_POS     = (1 << (mtx_pkg::SAMPLE_W - 1)) - 1;
  localparam int  FS_NEG     = -(1 << (mtx_pkg::SAMPLE_W - 1));
  localparam real PI         = 3.141592653589793;
  localparam real AMPL       = real'(mtx_pkg::TONE_AMPL);

  typedef struct packed {
    logic signed [31:0]          i;
    logic signed [31:0]          q;
    logic                        clip_i;  // model sum well past a rail
    logic                        clip_q;
    logic                        last;
    logic [mtx_pkg::SYMB_W-1:0]  symb;
    logic [mtx_pkg::PHASE_W-1:0] ph_a;
    logic [mtx_pkg::PHASE_W-1:0] ph_start;
  } model_t;

  logic                 clk;
  logic                 rst;
  logic                 restart;
  logic                 out_ready;
  mtx_pkg::iq_t         iq;
  logic                 out_valid;
  logic                 out_last;
  logic                 sync_ready;
  mtx_pkg::gen_status_t status;

  model_t       model_tab [FRAME_LEN];  // one frame, repeats every frame
  model_t       exp_out;                // next accepted output
  model_t       exp_beat;               // pending phase beat
  logic         exp_sync;
  logic         accept;
  logic         acc_seen;
  mtx_pkg::iq_t iq_prev;
  int           out_cnt;
  int           beat_cnt;
  int           cyc;
  int           acc_cyc;
  int           clip_cnt;
  int           err_cnt;
  int           err_mark;
  int           n_tests;
  int           n_failed;
  logic [31:0]  rng;

  mtx_sig_top u_mtx_sig_top (
    .clk        (clk),
    .rst        (rst),
    .restart    (restart),
    .out_ready  (out_ready),
    .iq         (iq),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .sync_ready (sync_ready),
    .status     (status)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic int round_real(input real x);
    if (x >= 0.0) begin
      return $rtoi(x + 0.5);
    end
    return -$rtoi(0.5 - x);
  endfunction

  function automatic int clamp16(input int v);
    if (v > FS_POS) begin
      return FS_POS;
    end
    if (v < FS_NEG) begin
      return FS_NEG;
    end
    return v;
  endfunction

  // lookup resolves the top ten phase bits, centre of each step
  function automatic real tone_angle(input logic [mtx_pkg::PHASE_W-1:0] ph);
    real steps;
    steps = real'(1 << (mtx_pkg::LUT_ADDR_W + 2));
    return 2.0 * PI * (real'(ph[mtx_pkg::PHASE_W-1 -: mtx_pkg::LUT_ADDR_W + 2]) + 0.5) / steps;
  endfunction

  function automatic model_t model_sample(input int k);
    model_t                      m;
    int                          s_idx;  // symbol, 0 based
    int                          n;
    logic [mtx_pkg::PHASE_W-1:0] inc_a;
    logic [mtx_pkg::PHASE_W-1:0] ph_b;
    real                         a_ang;
    real                         b_ang;
    real                         sum_i;
    real                         sum_q;
    s_idx      = k / mtx_pkg::NSIG;
    n          = k % mtx_pkg::NSIG;
    inc_a      = mtx_pkg::START_PH_INC + mtx_pkg::PHASE_W'(s_idx) * mtx_pkg::DPH_INC;
    m.ph_start = mtx_pkg::START_PH - mtx_pkg::PHASE_W'(s_idx) * mtx_pkg::NPH_SHIFT;
    m.ph_a     = m.ph_start + mtx_pkg::PHASE_W'(n) * inc_a;
    ph_b       = mtx_pkg::START_PH + mtx_pkg::PHASE_W'(n) * (inc_a + mtx_pkg::FREQ_SHIFT);
    a_ang      = tone_angle(m.ph_a);
    b_ang      = tone_angle(ph_b);
    sum_i      = AMPL * ($cos(a_ang) + $cos(b_ang));
    sum_q      = AMPL * ($sin(a_ang) + $sin(b_ang));
    m.i        = clamp16(round_real(sum_i));
    m.q        = clamp16(round_real(sum_q));
    m.clip_i   = sum_i > real'(FS_POS) + 4.0 || sum_i < real'(FS_NEG) - 4.0;
    m.clip_q   = sum_q > real'(FS_POS) + 4.0 || sum_q < real'(FS_NEG) - 4.0;
    m.last     = n == mtx_pkg::NSIG - 1;
    m.symb     = mtx_pkg::SYMB_W'(s_idx + 1);
    return m;
  endfunction

  function automatic logic close_enough(input logic signed [mtx_pkg::SAMPLE_W-1:0] got,
                                        input int want, input logic clip);
    int g;
    g = int'(got);
    if (clip) begin
      return g == want;  // must sit on the rail
    end
    return g - want <= TOL && want - g <= TOL;
  endfunction

  assign accept = u_mtx_sig_top.phase_valid && u_mtx_sig_top.phase_ready;

  always_comb begin
    exp_out  = model_tab[out_cnt[IDX_W-1:0]];
    exp_beat = model_tab[beat_cnt[IDX_W-1:0]];
    exp_sync = (beat_cnt / FRAME_LEN) % (1 << mtx_pkg::SYNC_BITS) == 0;
  end

  always @(posedge clk) begin
    cyc     <= cyc + 1;
    iq_prev <= iq;
    if (rst || restart) begin
      out_cnt  <= 0;
      beat_cnt <= 0;
      acc_seen <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_cnt <= out_cnt + 1;
        if (exp_out.clip_i || exp_out.clip_q) begin
          clip_cnt <= clip_cnt + 1;
        end
      end
      if (accept) begin
        beat_cnt <= beat_cnt + 1;
      end
      if (accept && !acc_seen) begin
        acc_seen <= 1'b1;
        acc_cyc  <= cyc;  // first beat after reset or restart
      end
    end
  end

  a_reset_quiet : assert property (@(posedge clk)
    cyc >= 2 && $past(rst) |-> !out_valid)
    else begin
      err_cnt++;
      $display("ERR %0t out_valid got %0b exp 0", $time, $sampled(out_valid));
    end

  a_reset_no_last : assert property (@(posedge clk)
    cyc >= 2 && $past(rst) |-> !out_last)
    else begin
      err_cnt++;
      $display("ERR %0t out_last got %0b exp 0", $time, $sampled(out_last));
    end

  a_first_latency : assert property (@(posedge clk) disable iff (rst)
    $rose(out_valid) && out_cnt == 0 |-> acc_seen && cyc == acc_cyc + 3)
    else begin
      err_cnt++;
      $display("ERR %0t out_valid first cycle got %0d exp %0d", $time, $sampled(cyc),
               $sampled(acc_cyc) + 3);
    end

  a_iq_i : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> close_enough(iq.i, exp_out.i, exp_out.clip_i))
    else begin
      err_cnt++;
      $display("ERR %0t iq.i got %0d exp %0d", $time, $sampled(iq.i), $sampled(exp_out.i));
    end

  a_iq_q : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> close_enough(iq.q, exp_out.q, exp_out.clip_q))
    else begin
      err_cnt++;
      $display("ERR %0t iq.q got %0d exp %0d", $time, $sampled(iq.q), $sampled(exp_out.q));
    end

  a_out_last : assert property (@(posedge clk) disable iff (rst)
    out_valid && out_ready |-> out_last == exp_out.last)
    else begin
      err_cnt++;
      $display("ERR %0t out_last got %0b exp %0b", $time, $sampled(out_last),
               $sampled(exp_out.last));
    end

  a_symb : assert property (@(posedge clk) disable iff (rst)
    accept |-> status.symb_n == exp_beat.symb)
    else begin
      err_cnt++;
      $display("ERR %0t status.symb_n got %0d exp %0d", $time, $sampled(status.symb_n),
               $sampled(exp_beat.symb));
    end

  a_sample_index : assert property (@(posedge clk) disable iff (rst)
    accept |-> status.sig_n == mtx_pkg::PHASE_W'(beat_cnt % mtx_pkg::NSIG))
    else begin
      err_cnt++;
      $display("ERR %0t status.sig_n got %0d exp %0d", $time, $sampled(status.sig_n),
               $sampled(beat_cnt) % mtx_pkg::NSIG);
    end

  a_start : assert property (@(posedge clk) disable iff (rst)
    accept |-> status.ph_start == exp_beat.ph_start)
    else begin
      err_cnt++;
      $display("ERR %0t status.ph_start got %h exp %h", $time, $sampled(status.ph_start),
               $sampled(exp_beat.ph_start));
    end

  a_phase : assert property (@(posedge clk) disable iff (rst)
    accept |-> status.ph == exp_beat.ph_a)
    else begin
      err_cnt++;
      $display("ERR %0t status.ph got %h exp %h", $time, $sampled(status.ph),
               $sampled(exp_beat.ph_a));
    end

  a_sync : assert property (@(posedge clk) disable iff (rst)
    u_mtx_sig_top.phase_valid |-> sync_ready == exp_sync)
    else begin
      err_cnt++;
      $display("ERR %0t sync_ready got %0b exp %0b", $time, $sampled(sync_ready),
               $sampled(exp_sync));
    end

  a_hold : assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready && !restart |=> out_valid && iq == iq_prev)
    else begin
      err_cnt++;
      $display("ERR %0t iq got %h exp %h", $time, $sampled(iq), $sampled(iq_prev));
    end

  task automatic wait_outputs(input int target, input int max_cycles);
    int waited;
    waited = 0;
    while (out_cnt < target && waited < max_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (out_cnt < target) begin
      err_cnt++;
      $display("timeout after %0d cycles with %0d outputs accepted, %0d wanted",
               max_cycles, out_cnt, target);
    end
  endtask

  task automatic wait_sample_index(input int n, input int max_cycles);
    int waited;
    waited = 0;
    while (status.sig_n != mtx_pkg::PHASE_W'(n) && waited < max_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (status.sig_n != mtx_pkg::PHASE_W'(n)) begin
      err_cnt++;
      $display("timeout waiting for sample index %0d", n);
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_cnt - err_mark;
    n_tests++;
    if (errs != 0) begin
      n_failed++;
    end
    $display("test %0d %s: %s, %0d errors", n_tests, name, errs == 0 ? "ok" : "not ok", errs);
    err_mark = err_cnt;
  endtask

  initial begin
    int start_cnt;
    rst       <= 1'b1;
    restart   <= 1'b0;
    out_ready <= 1'b1;
    cyc       <= 0;
    out_cnt   <= 0;
    beat_cnt  <= 0;
    acc_cyc   <= 0;
    acc_seen  <= 1'b0;
    clip_cnt  <= 0;
    err_cnt   = 0;
    err_mark  = 0;
    n_tests   = 0;
    n_failed  = 0;
    rng       = 32'd90787;
    for (int k = 0; k < FRAME_LEN; k++) begin
      model_tab[k] = model_sample(k);
    end

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    wait_outputs(1, 20);
    end_test("reset and first sample latency");

    wait_outputs(FRAME_LEN, FRAME_LEN + 50);
    if (clip_cnt == 0) begin
      err_cnt++;
      $display("no clipped sample was produced in frame 0");
    end
    end_test("tone values and clipping in frame 0");

    wait_outputs(8 * FRAME_LEN, 7 * FRAME_LEN + 50);
    end_test("last flag and status through frame 7");

    wait_outputs(9 * FRAME_LEN + 8, FRAME_LEN + 50);
    end_test("sync ready in frame 8");

    for (int c = 0; c < 800; c++) begin
      @(posedge clk);
      rng = xorshift32(rng);
      out_ready <= rng[0];
    end
    @(posedge clk);
    out_ready <= 1'b1;
    start_cnt = out_cnt;
    wait_outputs(start_cnt + 20, 100);
    end_test("random back-pressure");

    wait_sample_index(20, 200);  // mid symbol
    restart <= 1'b1;
    @(posedge clk);
    restart <= 1'b0;
    @(posedge clk);  // output count cleared by the restart
    wait_outputs(mtx_pkg::NSIG + 8, 200);
    end_test("restart in mid symbol");

    $display("tests %0d, not ok %0d, errors %0d", n_tests, n_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_T);
    $display("watchdog expired after %0d time units, run stopped", WATCHDOG_T);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- vlog.f
source/mtx_pkg.sv
source/chirp_phase_gen.sv
source/sin_cos_lut.sv
source/tone_combiner.sv
source/mtx_sig_top.sv
test/tb_mtx_sig.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_mtx_sig
LOG=sim.log

verilator --binary --assert -j 0 \
  --top-module "$TOP" \
  -f vlog.f

./obj_dir/V"$TOP" | tee "$LOG"

if grep -q "TB FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation finished without failure, log in $LOG"
exit 0
